//--- merger_4.f
hw/merge_pkg.sv
hw/block_fifo.sv
hw/bitonic_merge_8.sv
hw/merge_control.sv
hw/merger_4.sv
bench/tb_merger_4.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line in its output
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_merger_4 -f merger_4.f -o sim_merger_4 &&
out=$(./obj_dir/sim_merger_4 2>&1 || true) &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -qx "Test OK" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- bench/tb_merger_4.sv
`timescale 1ns/10ps

module tb_merger_4;

   logic              i_clk;
   logic              i_reset;
   merge_pkg::block_t i_a_block;
   logic              i_a_valid;
   logic              o_a_ready;
   merge_pkg::block_t i_b_block;
   logic              i_b_valid;
   logic              o_b_ready;
   merge_pkg::block_t o_out_block;
   logic              o_out_valid;
   logic              i_out_ready;

   merge_pkg::block_t  a_q[$];
   merge_pkg::block_t  b_q[$];
   merge_pkg::block_t  exp_q[$];
   merge_pkg::record_t pool[$];
   int                 budget_cycles = 100;

   merger_4 i_merger_4 (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_a_block   (i_a_block),
      .i_a_valid   (i_a_valid),
      .o_a_ready   (o_a_ready),
      .i_b_block   (i_b_block),
      .i_b_valid   (i_b_valid),
      .o_b_ready   (o_b_ready),
      .o_out_block (o_out_block),
      .o_out_valid (o_out_valid),
      .i_out_ready (i_out_ready)
   );

   initial i_clk = 1'b0;
   always #10 i_clk = ~i_clk;

   task automatic check_value(input string name, input logic [127:0] got,
                              input logic [127:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %0t %s: got %h expected %h", $time, name, got, exp);
         $display("Test FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // A keys are even and B keys odd, so the two runs never share a key
   task automatic push_run(input bit side_b, input int n_blocks, input int unsigned step_max);
      merge_pkg::block_t blk;
      int unsigned       cum;
      cum = 0;
      for (int b = 0; b < n_blocks; b++) begin
         for (int l = 0; l < merge_pkg::LANES; l++) begin
            cum = cum + 1 + ($urandom % step_max);
            blk[l].key = 16'(2 * cum + (side_b ? 1 : 0));
            blk[l].val = 16'($urandom);
            pool.push_back(blk[l]);
         end
         if (side_b) b_q.push_back(blk);
         else a_q.push_back(blk);
      end
      if (side_b) b_q.push_back('0);
      else a_q.push_back('0);
   endtask

   // Expected output is the sorted union of both runs, cut into blocks, then a terminator
   task automatic add_pair(input int na, input int nb, input int unsigned step_max);
      merge_pkg::record_t rec;
      merge_pkg::block_t  blk;
      int                 j;
      pool.delete();
      push_run(1'b0, na, step_max);
      push_run(1'b1, nb, step_max);
      for (int i = 1; i < pool.size(); i++) begin
         rec = pool[i];
         j = i - 1;
         while (j >= 0 && pool[j].key > rec.key) begin
            pool[j + 1] = pool[j];
            j--;
         end
         pool[j + 1] = rec;
      end
      for (int i = 0; i < pool.size(); i += merge_pkg::LANES) begin
         for (int l = 0; l < merge_pkg::LANES; l++) begin
            blk[l] = pool[i + l];
         end
         exp_q.push_back(blk);
      end
      exp_q.push_back('0);
      budget_cycles = budget_cycles + 200 * (na + nb + 2);
   endtask

   // Valid is only dropped for a gap while no block is on offer
   task automatic send_side(input bit side_b, input int unsigned gap_pct);
      merge_pkg::block_t blk;
      logic              show;
      logic              ready;
      show = 1'b0;
      while ((side_b ? b_q.size() : a_q.size()) > 0) begin
         blk = side_b ? b_q[0] : a_q[0];
         @(posedge i_clk);
         if (!show) show = ($urandom % 100) >= gap_pct;
         if (side_b) begin
            i_b_valid <= show;
            i_b_block <= blk;
         end else begin
            i_a_valid <= show;
            i_a_block <= blk;
         end
         @(negedge i_clk);
         ready = side_b ? o_b_ready : o_a_ready;
         if (show && ready) begin
            if (side_b) blk = b_q.pop_front();
            else blk = a_q.pop_front();
            show = 1'b0;
         end
      end
      @(posedge i_clk);
      if (side_b) i_b_valid <= 1'b0;
      else i_a_valid <= 1'b0;
   endtask

   task automatic collect(input int unsigned stall_pct);
      merge_pkg::block_t expected;
      int                idx;
      idx = 0;
      while (exp_q.size() > 0) begin
         @(posedge i_clk);
         i_out_ready <= ($urandom % 100) >= stall_pct;
         @(negedge i_clk);
         if (o_out_valid && i_out_ready) begin
            expected = exp_q.pop_front();
            check_value($sformatf("o_out_block[%0d]", idx), o_out_block, expected);
            idx++;
         end
      end
      @(posedge i_clk);
      i_out_ready <= 1'b0;
   endtask

   // Anything left in the output after the terminator is a duplicate
   task automatic check_drained();
      repeat (10) @(negedge i_clk);
      check_value("o_out_valid", 128'(o_out_valid), 128'(0));
   endtask

   task automatic run_traffic(input int unsigned gap_pct, input int unsigned stall_pct);
      fork
         send_side(1'b0, gap_pct);
         send_side(1'b1, gap_pct);
         collect(stall_pct);
      join
      check_drained();
   endtask

   task automatic wait_a_full();
      int waited;
      waited = 0;
      while (o_a_ready && waited < 400) begin
         @(negedge i_clk);
         waited++;
      end
      if (o_a_ready) begin
         $display("o_a_ready stayed high although the output was stalled for 400 cycles");
         $display("Test FAILED");
         $fatal(1, "input FIFO never filled");
      end
   endtask

   task automatic test_reset_state();
      check_value("o_out_valid", 128'(o_out_valid), 128'(0));
      check_value("o_a_ready", 128'(o_a_ready), 128'(1));
      check_value("o_b_ready", 128'(o_b_ready), 128'(1));
   endtask

   task automatic test_short_interleaved();
      add_pair(2, 2, 1);
      run_traffic(0, 0);
   endtask

   task automatic test_empty_runs();
      add_pair(0, 3, 3);
      run_traffic(0, 0);
      add_pair(3, 0, 3);
      run_traffic(0, 0);
      add_pair(0, 0, 1);
      run_traffic(0, 0);
   endtask

   task automatic test_random_runs();
      int na;
      int nb;
      for (int n = 0; n < 6; n++) begin
         na = int'($urandom % 11);
         nb = int'($urandom % 11);
         add_pair(na, nb, 4);
         run_traffic(30, 30);
      end
   endtask

   task automatic test_back_to_back();
      add_pair(3, 2, 3);
      add_pair(1, 4, 3);
      add_pair(2, 2, 2);
      run_traffic(10, 10);
   endtask

   task automatic test_backpressure();
      add_pair(30, 1, 2);
      fork
         send_side(1'b0, 0);
         send_side(1'b1, 0);
         begin
            wait_a_full();
            check_value("o_out_valid", 128'(o_out_valid), 128'(1));
            collect(0);
         end
      join
      check_drained();
   endtask

   initial begin : watchdog
      int elapsed;
      elapsed = 0;
      while (elapsed <= budget_cycles) begin
         @(posedge i_clk);
         elapsed++;
      end
      $display("Timeout after %0d cycles with the merge still running", elapsed);
      $display("Test FAILED");
      $fatal(1, "watchdog expired");
   end

   initial begin
      void'($urandom(32'h67c9ff4f));
      i_reset     = 1'b1;
      i_a_block   = '0;
      i_a_valid   = 1'b0;
      i_b_block   = '0;
      i_b_valid   = 1'b0;
      i_out_ready = 1'b0;
      repeat (2) @(posedge i_clk);
      i_reset <= 1'b0;
      @(negedge i_clk);
      test_reset_state();
      test_short_interleaved();
      test_empty_runs();
      test_random_runs();
      test_back_to_back();
      test_backpressure();
      $display("Test OK");
      $finish;
   end

endmodule

//--- hw/merger_4.sv
`timescale 1ns/10ps

module merger_4 (
   input  logic              i_clk,
   input  logic              i_reset,

   input  merge_pkg::block_t i_a_block,
   input  logic              i_a_valid,
   output logic              o_a_ready,

   input  merge_pkg::block_t i_b_block,
   input  logic              i_b_valid,
   output logic              o_b_ready,

   output merge_pkg::block_t o_out_block,
   output logic              o_out_valid,
   input  logic              i_out_ready
);

   merge_pkg::block_t a_head;
   merge_pkg::block_t b_head;
   merge_pkg::block_t sel_head;
   merge_pkg::block_t held_q;
   merge_pkg::block_t held_cur;
   merge_pkg::block_t net_lo;
   merge_pkg::block_t net_hi;
   merge_pkg::block_t out_wr_block;

   logic a_head_valid;
   logic b_head_valid;
   logic take_a;
   logic take_b;
   logic issue;
   logic emit_term;
   logic net_valid;
   logic flush_wr;
   logic prime_load;
   logic out_wr;

   merge_pkg::ctrl_state_t          state;
   logic [merge_pkg::OUT_FREE_W-1:0] out_free;

   block_fifo #(.DEPTH(merge_pkg::IN_DEPTH)) i_fifo_a (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_block (i_a_block),
      .i_valid (i_a_valid),
      .i_deq   (take_a),
      .o_ready (o_a_ready),
      .o_block (a_head),
      .o_valid (a_head_valid),
      .o_free  ()
   );

   block_fifo #(.DEPTH(merge_pkg::IN_DEPTH)) i_fifo_b (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_block (i_b_block),
      .i_valid (i_b_valid),
      .i_deq   (take_b),
      .o_ready (o_b_ready),
      .o_block (b_head),
      .o_valid (b_head_valid),
      .o_free  ()
   );

   merge_control i_control (
      .i_clk       (i_clk),
      .i_reset     (i_reset),
      .i_a_head    (a_head),
      .i_a_valid   (a_head_valid),
      .i_b_head    (b_head),
      .i_b_valid   (b_head_valid),
      .i_out_free  (out_free),
      .o_take_a    (take_a),
      .o_take_b    (take_b),
      .o_issue     (issue),
      .o_emit_term (emit_term),
      .o_state     (state)
   );

   assign sel_head = take_a ? a_head : b_head;

   // Back-to-back merge steps see the upper half straight from the network register
   assign held_cur = net_valid ? net_hi : held_q;

   bitonic_merge_8 i_network (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_valid (issue),
      .i_lo    (sel_head),
      .i_hi    (held_cur),
      .o_valid (net_valid),
      .o_lo    (net_lo),
      .o_hi    (net_hi)
   );

   // PRIME takes a single head straight into the held register
   assign prime_load = (state == merge_pkg::PRIME) & (take_a ^ take_b);
   assign flush_wr   = (state == merge_pkg::FLUSH) & take_a;

   always_ff @(posedge i_clk) begin
      if (net_valid) begin
         held_q <= net_hi;
      end else if (prime_load) begin
         held_q <= sel_head;
      end
   end

   // Control keeps these three write sources in separate cycles
   always_comb begin
      out_wr       = net_valid | flush_wr | emit_term;
      out_wr_block = net_lo;
      if (flush_wr) begin
         out_wr_block = held_cur;
      end else if (emit_term) begin
         out_wr_block = '0;
      end
   end

   block_fifo #(.DEPTH(merge_pkg::OUT_DEPTH)) i_fifo_out (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_block (out_wr_block),
      .i_valid (out_wr),
      .i_deq   (i_out_ready),
      .o_ready (),
      .o_block (o_out_block),
      .o_valid (o_out_valid),
      .o_free  (out_free)
   );

endmodule

//--- hw/merge_control.sv
`timescale 1ns/10ps

module merge_control (
   input  logic                               i_clk,
   input  logic                               i_reset,
   input  merge_pkg::block_t                  i_a_head,
   input  logic                               i_a_valid,
   input  merge_pkg::block_t                  i_b_head,
   input  logic                               i_b_valid,
   input  logic [merge_pkg::OUT_FREE_W-1:0]   i_out_free,
   output logic                               o_take_a,
   output logic                               o_take_b,
   output logic                               o_issue,
   output logic                               o_emit_term,
   output merge_pkg::ctrl_state_t             o_state
);

   merge_pkg::ctrl_state_t state_q;
   merge_pkg::ctrl_state_t state_d;

   logic a_term;
   logic b_term;
   logic both_valid;
   logic both_term;
   logic a_first;
   logic space;

   // A zero key in lane 0 marks the terminator block of a run
   assign a_term     = (i_a_head[0].key == '0);
   assign b_term     = (i_b_head[0].key == '0);
   assign both_valid = i_a_valid & i_b_valid;
   assign both_term  = a_term & b_term;

   // A wins ties; a terminated side is never chosen
   assign a_first = b_term | (!a_term && (i_a_head[0].key <= i_b_head[0].key));

   assign space = (i_out_free >= merge_pkg::OUT_FREE_W'(merge_pkg::OUT_MARGIN));

   assign o_state = state_q;

   always_comb begin
      state_d     = state_q;
      o_take_a    = 1'b0;
      o_take_b    = 1'b0;
      o_issue     = 1'b0;
      o_emit_term = 1'b0;

      case (state_q)
         merge_pkg::PRIME: begin
            if (both_valid && space) begin
               if (both_term) begin
                  o_take_a = 1'b1;
                  o_take_b = 1'b1;
                  state_d  = merge_pkg::TERM;
               end else begin
                  o_take_a = a_first;
                  o_take_b = !a_first;
                  state_d  = merge_pkg::MERGE;
               end
            end
         end
         merge_pkg::MERGE: begin
            if (both_valid && space) begin
               if (both_term) begin
                  state_d = merge_pkg::FLUSH;
               end else begin
                  o_take_a = a_first;
                  o_take_b = !a_first;
                  o_issue  = 1'b1;
               end
            end
         end
         merge_pkg::FLUSH: begin
            if (space) begin
               o_take_a = 1'b1;
               o_take_b = 1'b1;
               state_d  = merge_pkg::TERM;
            end
         end
         merge_pkg::TERM: begin
            if (space) begin
               o_emit_term = 1'b1;
               state_d     = merge_pkg::PRIME;
            end
         end
         default: begin
            state_d = merge_pkg::PRIME;
         end
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         state_q <= merge_pkg::PRIME;
      end else begin
         state_q <= state_d;
      end
   end

endmodule

//--- hw/bitonic_merge_8.sv
`timescale 1ns/10ps

module bitonic_merge_8 (
   input  logic              i_clk,
   input  logic              i_reset,
   input  logic              i_valid,
   input  merge_pkg::block_t i_lo,
   input  merge_pkg::block_t i_hi,
   output logic              o_valid,
   output merge_pkg::block_t o_lo,
   output merge_pkg::block_t o_hi
);

   merge_pkg::record_t [7:0] s0;
   merge_pkg::record_t [7:0] s1;
   merge_pkg::record_t [7:0] s2;
   merge_pkg::record_t [7:0] s3;

   // Equal keys keep the first argument on the low side
   function automatic merge_pkg::record_t min_rec(merge_pkg::record_t x,
                                                  merge_pkg::record_t y);
      return (x.key <= y.key) ? x : y;
   endfunction

   function automatic merge_pkg::record_t max_rec(merge_pkg::record_t x,
                                                  merge_pkg::record_t y);
      return (x.key <= y.key) ? y : x;
   endfunction

   always_comb begin
      // Ascending low block followed by reversed high block forms a bitonic sequence
      for (int i = 0; i < 4; i++) begin
         s0[i]     = i_lo[i];
         s0[i + 4] = i_hi[3 - i];
      end

      // Half cleaner at distance 4
      for (int i = 0; i < 4; i++) begin
         s1[i]     = min_rec(s0[i], s0[i + 4]);
         s1[i + 4] = max_rec(s0[i], s0[i + 4]);
      end

      // Distance 2 within each half
      for (int j = 0; j < 4; j++) begin
         s2[(j / 2) * 4 + (j % 2)]     = min_rec(s1[(j / 2) * 4 + (j % 2)],
                                                 s1[(j / 2) * 4 + (j % 2) + 2]);
         s2[(j / 2) * 4 + (j % 2) + 2] = max_rec(s1[(j / 2) * 4 + (j % 2)],
                                                 s1[(j / 2) * 4 + (j % 2) + 2]);
      end

      // Distance 1 finishes the sort
      for (int j = 0; j < 4; j++) begin
         s3[2 * j]     = min_rec(s2[2 * j], s2[2 * j + 1]);
         s3[2 * j + 1] = max_rec(s2[2 * j], s2[2 * j + 1]);
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         o_valid <= 1'b0;
      end else begin
         o_valid <= i_valid;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_valid) begin
         o_lo <= s3[3:0];
         o_hi <= s3[7:4];
      end
   end

endmodule

//--- hw/block_fifo.sv
`timescale 1ns/10ps

module block_fifo #(
   parameter int DEPTH = 16
) (
   input  logic                         i_clk,
   input  logic                         i_reset,
   input  merge_pkg::block_t            i_block,
   input  logic                         i_valid,
   input  logic                         i_deq,
   output logic                         o_ready,
   output merge_pkg::block_t            o_block,
   output logic                         o_valid,
   output logic [$clog2(DEPTH+1)-1:0]   o_free
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   merge_pkg::block_t mem [DEPTH];

   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_enq;
   logic             do_deq;

   assign o_ready = (count != CNT_W'(DEPTH));
   assign o_valid = (count != '0);
   assign o_free  = CNT_W'(DEPTH) - count;

   // Head is visible before it is dequeued
   assign o_block = mem[rd_ptr];

   assign do_enq = i_valid & o_ready;
   assign do_deq = i_deq & o_valid;

   always_ff @(posedge i_clk) begin
      if (do_enq) begin
         mem[wr_ptr] <= i_block;
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_enq) begin
            wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_deq) begin
            rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
         end
         if (do_enq && !do_deq) begin
            count <= count + 1'b1;
         end else if (do_deq && !do_enq) begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

//--- hw/merge_pkg.sv
package merge_pkg;

   localparam int KEY_W = 16;
   localparam int VAL_W = 16;
   localparam int LANES = 4;

   localparam int IN_DEPTH  = 16;
   localparam int OUT_DEPTH = 8;

   // One entry for the block in the network register, one for the block being issued
   localparam int OUT_MARGIN = 2;
   localparam int OUT_FREE_W = $clog2(OUT_DEPTH + 1);

   typedef struct packed {
      logic [KEY_W-1:0] key;
      logic [VAL_W-1:0] val;
   } record_t;

   // Lane 0 holds the lowest key of the block
   typedef record_t [LANES-1:0] block_t;

   typedef enum logic [2:0] {
      PRIME,
      MERGE,
      FLUSH,
      TERM
   } ctrl_state_t;

endpackage
